// ==== hdl/mem_map_pkg.sv ====
package mem_map_pkg;

  // ************************************************************************
  // Basic address and data types.
  // ************************************************************************

  typedef logic [31:0] addr_t;   // Byte address.
  typedef logic [31:0] word_t;   // Stack data word.
  typedef logic [31:0] instr_t;  // Text word, kept apart from data words.

  // Word geometry.
  localparam int WORD_BYTES = 4;
  localparam int ADDR_LSB   = $clog2(WORD_BYTES);  // Byte offset bits dropped for index.
  localparam int BYTE_BITS  = 8;

  // Inclusive byte window of one region.
  typedef struct packed {
    addr_t lo;
    addr_t hi;
  } region_t;

  // ************************************************************************
  // Reset windows of the two regions.
  // ************************************************************************

  // Text sits at the bottom of the map, 1 KiB.
  localparam addr_t TEXT_LO_DEFAULT  = 32'h0000_0000;
  localparam addr_t TEXT_HI_DEFAULT  = 32'h0000_03ff;

  // Stack directly above text, 1 KiB.
  localparam addr_t STACK_LO_DEFAULT = 32'h0000_0400;
  localparam addr_t STACK_HI_DEFAULT = 32'h0000_07ff;

endpackage

// ==== hdl/mem_bus_pkg.sv ====
package mem_bus_pkg;

  import mem_map_pkg::*;

  // Data port request, sampled every cycle.
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } data_req_t;

  // Program load into text memory.
  typedef struct packed {
    logic   valid;
    addr_t  addr;
    instr_t data;
  } load_req_t;

  // Target of a config write.
  typedef enum logic [2:0] {
    CFG_TEXT_LO   = 3'd0,
    CFG_TEXT_HI   = 3'd1,
    CFG_STACK_LO  = 3'd2,
    CFG_STACK_HI  = 3'd3,
    CFG_FAULT_CLR = 3'd4   // Value is ignored.
  } cfg_sel_t;

  typedef struct packed {
    logic     valid;
    cfg_sel_t sel;
    addr_t    value;
  } cfg_req_t;

  // Sticky out-of-bounds flags.
  typedef struct packed {
    logic fetch_oob;
    logic data_oob;
    logic load_oob;
  } fault_t;

  // String printer interface.
  typedef struct packed {
    logic  start;
    addr_t addr;    // Byte address of the first character.
  } print_req_t;

  typedef struct packed {
    logic                 valid;
    logic [BYTE_BITS-1:0] ch;
  } char_out_t;

endpackage

// ==== hdl/word_ram.sv ====
`timescale 1ns/1ps

// Synchronous RAM, one write port and two registered read ports.
module word_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 256
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr_a,
  output payload_t                 rdata_a,
  input  logic [$clog2(DEPTH)-1:0] raddr_b,
  output payload_t                 rdata_b
);

  payload_t mem [DEPTH];  // Storage array.

  // ************************************************************************
  // Write port.
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ************************************************************************
  // Read ports.
  // ************************************************************************

  // A read of the address being written returns the old word.
  always_ff @(posedge clk) begin
    rdata_a <= mem[raddr_a];
  end

  always_ff @(posedge clk) begin
    rdata_b <= mem[raddr_b];  // Second port, used by the printer on text.
  end

endmodule

// ==== hdl/region_cfg.sv ====
`timescale 1ns/1ps

// Region bounds, range checks and sticky fault status.
module region_cfg
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  cfg_req_t cfg_req,
  input  addr_t    fetch_addr,
  input  addr_t    data_addr,
  input  addr_t    load_addr,
  input  logic     data_access,
  input  logic     load_valid,
  output logic     fetch_ok,
  output logic     data_ok,
  output logic     load_ok,
  output fault_t   fault_status
);

  region_t text_win;
  region_t stack_win;
  fault_t  fault_set;
  logic    fault_clr;

  // Inclusive window test.
  function automatic logic in_window(input addr_t a, input region_t r);
    return (a >= r.lo) && (a <= r.hi);
  endfunction

  // ************************************************************************
  // Bounds registers.
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      text_win.lo  <= TEXT_LO_DEFAULT;
      text_win.hi  <= TEXT_HI_DEFAULT;
      stack_win.lo <= STACK_LO_DEFAULT;
      stack_win.hi <= STACK_HI_DEFAULT;
    end else if (cfg_req.valid) begin
      case (cfg_req.sel)
        CFG_TEXT_LO:  text_win.lo  <= cfg_req.value;
        CFG_TEXT_HI:  text_win.hi  <= cfg_req.value;
        CFG_STACK_LO: stack_win.lo <= cfg_req.value;
        CFG_STACK_HI: stack_win.hi <= cfg_req.value;
        default:      ;  // Fault clear handled below.
      endcase
    end
  end

  // ************************************************************************
  // Range checks, one level per port.
  // ************************************************************************

  assign fetch_ok = in_window(fetch_addr, text_win);
  assign data_ok  = in_window(data_addr, stack_win);
  assign load_ok  = in_window(load_addr, text_win);

  // New faults this cycle.
  always_comb begin
    fault_set.fetch_oob = !fetch_ok;
    fault_set.data_oob  = data_access && !data_ok;
    fault_set.load_oob  = load_valid && !load_ok;
  end

  assign fault_clr = cfg_req.valid && (cfg_req.sel == CFG_FAULT_CLR);

  // Sticky status. Clear wins over a fault in the same cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      fault_status <= '0;
    end else if (fault_clr) begin
      fault_status <= '0;
    end else begin
      fault_status <= fault_status | fault_set;
    end
  end

endmodule

// ==== hdl/string_printer.sv ====
`timescale 1ns/1ps

// Walks a null-terminated string in text memory, one char per cycle.
module string_printer
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int TEXT_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          reset,
  input  print_req_t                    print_req,
  output logic [$clog2(TEXT_WORDS)-1:0] text_raddr,
  input  instr_t                        text_rdata,
  output char_out_t                     char_out,
  output logic                          busy,
  output logic                          print_done
);

  localparam int TEXT_AW = $clog2(TEXT_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,  // Address on the read port.
    ST_WAIT,   // Word arrives from the RAM.
    ST_EMIT    // One byte per cycle.
  } state_t;

  state_t               state;
  logic [TEXT_AW-1:0]   word_ptr;
  logic [ADDR_LSB-1:0]  byte_off;
  instr_t               word_q;
  logic [BYTE_BITS-1:0] cur_byte;
  logic                 char_valid_q;
  logic [BYTE_BITS-1:0] char_q;

  assign text_raddr = word_ptr;
  assign busy       = (state != ST_IDLE);

  // Big-endian byte select.
  always_comb begin
    case (byte_off)
      2'd0:    cur_byte = word_q[31:24];
      2'd1:    cur_byte = word_q[23:16];
      2'd2:    cur_byte = word_q[15:8];
      default: cur_byte = word_q[7:0];
    endcase
  end

  // ************************************************************************
  // Control FSM.
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_IDLE;
      word_ptr     <= '0;
      byte_off     <= '0;
      char_valid_q <= 1'b0;
      print_done   <= 1'b0;
    end else begin
      char_valid_q <= 1'b0;
      print_done   <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (print_req.start) begin  // Start while busy never reaches here.
            word_ptr <= print_req.addr[ADDR_LSB +: TEXT_AW];
            byte_off <= print_req.addr[ADDR_LSB-1:0];
            state    <= ST_FETCH;
          end
        end
        ST_FETCH: state <= ST_WAIT;
        ST_WAIT:  state <= ST_EMIT;
        ST_EMIT: begin
          if (cur_byte == '0) begin
            print_done <= 1'b1;  // Terminator, no char for it.
            state      <= ST_IDLE;
          end else begin
            char_valid_q <= 1'b1;
            byte_off     <= byte_off + 1'b1;
            if (byte_off == '1) begin
              word_ptr <= word_ptr + 1'b1;  // Wraps at TEXT_WORDS.
              state    <= ST_FETCH;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (state == ST_WAIT) begin
      word_q <= text_rdata;
    end
    if (state == ST_EMIT) begin
      char_q <= cur_byte;
    end
  end

  assign char_out = '{valid: char_valid_q, ch: char_q};

endmodule

// ==== hdl/mips_memory.sv ====
`timescale 1ns/1ps

// Text and stack memories with gated writes and zeroed out-of-range reads.
module mips_memory
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int TEXT_WORDS  = 256,
  parameter int STACK_WORDS = 256
) (
  input  logic       clk,
  input  logic       reset,
  input  addr_t      fetch_addr,
  output instr_t     instr_out,
  input  data_req_t  data_req,
  output word_t      rdata,
  input  load_req_t  load_req,
  input  logic       fetch_ok,
  input  logic       data_ok,
  input  logic       load_ok,
  input  print_req_t print_req,
  output char_out_t  char_out,
  output logic       busy,
  output logic       print_done
);

  localparam int TEXT_AW  = $clog2(TEXT_WORDS);
  localparam int STACK_AW = $clog2(STACK_WORDS);

  logic [TEXT_AW-1:0]  fetch_idx;
  logic [TEXT_AW-1:0]  load_idx;
  logic [TEXT_AW-1:0]  print_idx;
  logic [STACK_AW-1:0] data_idx;
  instr_t              fetch_word;
  instr_t              print_word;
  word_t               stack_word;
  logic                fetch_ok_q;
  logic                data_ok_q;

  // Byte address to word index.
  assign fetch_idx = fetch_addr[ADDR_LSB +: TEXT_AW];
  assign load_idx  = load_req.addr[ADDR_LSB +: TEXT_AW];
  assign data_idx  = data_req.addr[ADDR_LSB +: STACK_AW];

  // ************************************************************************
  // Text memory. Port A serves fetch, port B the printer.
  // ************************************************************************

  word_ram #(
    .payload_t (instr_t),
    .DEPTH     (TEXT_WORDS)
  ) u_text_ram (
    .clk     (clk),
    .we      (load_req.valid && load_ok),  // Loads outside the window are dropped.
    .waddr   (load_idx),
    .wdata   (load_req.data),
    .raddr_a (fetch_idx),
    .rdata_a (fetch_word),
    .raddr_b (print_idx),
    .rdata_b (print_word)
  );

  // ************************************************************************
  // Stack memory. Second read port stays idle.
  // ************************************************************************

  word_ram #(
    .payload_t (word_t),
    .DEPTH     (STACK_WORDS)
  ) u_stack_ram (
    .clk     (clk),
    .we      (data_req.write && data_ok),
    .waddr   (data_idx),
    .wdata   (data_req.wdata),
    .raddr_a (data_idx),
    .rdata_a (stack_word),
    .raddr_b ('0),
    .rdata_b ()
  );

  // Range results follow the RAM read by one cycle.
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_ok_q <= 1'b0;
      data_ok_q  <= 1'b0;
    end else begin
      fetch_ok_q <= fetch_ok;
      data_ok_q  <= data_ok;
    end
  end

  assign instr_out = fetch_ok_q ? fetch_word : '0;
  assign rdata     = data_ok_q ? stack_word : '0;

  // ************************************************************************
  // String printer on text port B.
  // ************************************************************************

  string_printer #(
    .TEXT_WORDS (TEXT_WORDS)
  ) u_printer (
    .clk        (clk),
    .reset      (reset),
    .print_req  (print_req),
    .text_raddr (print_idx),
    .text_rdata (print_word),
    .char_out   (char_out),
    .busy       (busy),
    .print_done (print_done)
  );

endmodule

// ==== hdl/mem_subsystem_top.sv ====
`timescale 1ns/1ps

// Memory subsystem, region checks beside the memories.
module mem_subsystem_top
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int TEXT_WORDS  = 256,
  parameter int STACK_WORDS = 256
) (
  input  logic       clk,
  input  logic       reset,
  input  addr_t      fetch_addr,
  output instr_t     instr_out,
  input  logic       data_valid,
  input  data_req_t  data_req,
  output word_t      rdata,
  input  load_req_t  load_req,
  input  cfg_req_t   cfg_req,
  output fault_t     fault_status,
  input  print_req_t print_req,
  output char_out_t  char_out,
  output logic       busy,
  output logic       print_done
);

  logic fetch_ok;
  logic data_ok;
  logic load_ok;

  region_cfg u_region_cfg (
    .clk          (clk),
    .reset        (reset),
    .cfg_req      (cfg_req),
    .fetch_addr   (fetch_addr),
    .data_addr    (data_req.addr),
    .load_addr    (load_req.addr),
    .data_access  (data_valid),
    .load_valid   (load_req.valid),
    .fetch_ok     (fetch_ok),
    .data_ok      (data_ok),
    .load_ok      (load_ok),
    .fault_status (fault_status)
  );

  mips_memory #(
    .TEXT_WORDS  (TEXT_WORDS),
    .STACK_WORDS (STACK_WORDS)
  ) u_mips_memory (
    .clk        (clk),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .instr_out  (instr_out),
    .data_req   (data_req),
    .rdata      (rdata),
    .load_req   (load_req),
    .fetch_ok   (fetch_ok),
    .data_ok    (data_ok),
    .load_ok    (load_ok),
    .print_req  (print_req),
    .char_out   (char_out),
    .busy       (busy),
    .print_done (print_done)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench.
module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Released on a falling edge, away from the sampling edge.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb
  import mem_map_pkg::*;
  import mem_bus_pkg::*;
;

  localparam int TEXT_WORDS  = 256;
  localparam int STACK_WORDS = 256;
  localparam int TEXT_AW     = $clog2(TEXT_WORDS);
  localparam int STACK_AW    = $clog2(STACK_WORDS);

  typedef enum logic [2:0] {
    OP_LOAD, OP_FETCH, OP_WRITE, OP_READ, OP_RDWR, OP_CFG, OP_FAULT, OP_PRINT
  } op_t;

  // One stimulus step. arg is the fetch count, or the string index for a print.
  typedef struct packed {
    op_t      op;
    cfg_sel_t sel;
    addr_t    addr;
    word_t    data;
    logic [7:0] arg;
  } entry_t;

  logic       clk;
  logic       reset;
  addr_t      fetch_addr;
  instr_t     instr_out;
  logic       data_valid;
  data_req_t  data_req;
  word_t      rdata;
  load_req_t  load_req;
  cfg_req_t   cfg_req;
  fault_t     fault_status;
  print_req_t print_req;
  char_out_t  char_out;
  logic       busy;
  logic       print_done;

  entry_t      stim_q[$];
  string       print_strs [2];
  int unsigned cycles      = 0;
  int unsigned cycle_limit = 0;

  // Reference model state.
  instr_t  text_model  [TEXT_WORDS];
  word_t   stack_model [STACK_WORDS];
  region_t text_win_m;
  region_t stack_win_m;
  fault_t  fault_m;

  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) clk_gen_i (.clk(clk), .reset(reset));

  mem_subsystem_top #(
    .TEXT_WORDS  (TEXT_WORDS),
    .STACK_WORDS (STACK_WORDS)
  ) dut_i (.*);

  // ************************************************************************
  // Failure reporting and compare tasks.
  // ************************************************************************

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_instr(input instr_t got, input instr_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_fault(input fault_t got, input fault_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_char(input char_out_t got, input char_out_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // ************************************************************************
  // Reference model.
  // ************************************************************************

  function automatic logic in_win(input addr_t a, input region_t r);
    return (a >= r.lo) && (a <= r.hi);
  endfunction

  function automatic int text_idx(input addr_t a);
    return int'(a[2 +: TEXT_AW]);  // Word index wraps with the RAM depth.
  endfunction

  function automatic instr_t predict_fetch(input addr_t a);
    if (!in_win(a, text_win_m)) begin
      fault_m.fetch_oob = 1'b1;
      return '0;
    end
    return text_model[text_idx(a)];
  endfunction

  // ************************************************************************
  // Port drivers, all on the falling edge.
  // ************************************************************************

  task automatic drive_load(input addr_t a, input instr_t d);
    @(negedge clk);
    load_req = '{valid: 1'b1, addr: a, data: d};
    if (in_win(a, text_win_m)) text_model[text_idx(a)] = d;
    else fault_m.load_oob = 1'b1;
    @(negedge clk);
    load_req.valid = 1'b0;
  endtask

  task automatic run_fetches(input addr_t a, input int n);
    instr_t exp_word;
    int     i;
    for (i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i > 0) check_instr(instr_out, exp_word, "fetch");
      if (i < n) begin
        fetch_addr = a + 4 * i;  // Back to back, one per cycle.
        exp_word   = predict_fetch(fetch_addr);
      end
    end
    fetch_addr = '0;
  endtask

  // Stack access. A read shows the word from before any write in the same cycle.
  task automatic stack_access(input addr_t a, input word_t d, input logic wr, input logic rd);
    word_t exp_word;
    int    idx;
    idx = int'(a[2 +: STACK_AW]);
    @(negedge clk);
    data_valid = 1'b1;
    data_req   = '{write: wr, addr: a, wdata: d};
    exp_word   = in_win(a, stack_win_m) ? stack_model[idx] : '0;
    if (!in_win(a, stack_win_m)) fault_m.data_oob = 1'b1;
    else if (wr) stack_model[idx] = d;
    @(negedge clk);
    data_valid     = 1'b0;
    data_req.write = 1'b0;
    if (rd) check_word(rdata, exp_word, "stack read");
  endtask

  task automatic write_cfg(input cfg_sel_t sel, input addr_t value);
    @(negedge clk);
    cfg_req = '{valid: 1'b1, sel: sel, value: value};
    case (sel)
      CFG_TEXT_LO:  text_win_m.lo  = value;
      CFG_TEXT_HI:  text_win_m.hi  = value;
      CFG_STACK_LO: stack_win_m.lo = value;
      CFG_STACK_HI: stack_win_m.hi = value;
      default:      fault_m        = '0;
    endcase
    @(negedge clk);
    cfg_req.valid = 1'b0;
  endtask

  // Writes the string and its terminator byte by byte, then loads the touched words.
  task automatic load_string(input addr_t a, input string s);
    addr_t      b;
    logic [7:0] ch;
    int         i;
    for (i = 0; i <= s.len(); i++) begin
      b  = a + i;
      ch = (i == s.len()) ? 8'h00 : s[i];
      text_model[text_idx(b)][31 - 8 * int'(b[1:0]) -: 8] = ch;
    end
    for (b = {a[31:2], 2'b00}; b <= a + s.len(); b += 4) begin
      drive_load(b, text_model[text_idx(b)]);
    end
  endtask

  task automatic run_print(input addr_t a, input string s);
    instr_t    fexp;
    char_out_t want;
    int        k;
    int        cyc;
    logic      done;
    load_string(a, s);
    @(negedge clk);
    print_req = '{start: 1'b1, addr: a};
    @(negedge clk);
    print_req.start = 1'b0;
    check_flag(busy, 1'b1, "busy after start");
    k    = 0;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (cyc > 0) check_instr(instr_out, fexp, "fetch during print");
      if (cyc == 2) print_req = '{start: 1'b1, addr: 32'h180};  // Ignored start.
      else print_req = '0;
      if (char_out.valid) begin
        if (k >= s.len()) begin
          $display("printer emitted more characters than the string holds");
          stop_run();
        end
        want = '{valid: 1'b1, ch: s[k]};
        check_char(char_out, want, "printed char");
        k++;
      end
      if (print_done) begin
        check_flag(busy, 1'b0, "busy with print_done");
        if (k != s.len()) begin
          $display("printer finished after %0d of %0d characters", k, s.len());
          stop_run();
        end
        done = 1'b1;
      end
      fetch_addr = addr_t'((cyc % 8) * 4);
      fexp       = predict_fetch(fetch_addr);
      cyc++;
    end
    repeat (3) begin
      @(negedge clk);
      check_instr(instr_out, fexp, "fetch after print");
      fetch_addr = '0;
      fexp       = predict_fetch(fetch_addr);
      check_flag(char_out.valid, 1'b0, "char after done");
      check_flag(print_done, 1'b0, "second print_done");
      check_flag(busy, 1'b0, "busy after done");
    end
  endtask

  // ************************************************************************
  // Stimulus table.
  // ************************************************************************

  function automatic void add_entry(op_t op, cfg_sel_t sel, addr_t a, word_t d, int arg);
    stim_q.push_back('{op: op, sel: sel, addr: a, data: d, arg: arg[7:0]});
  endfunction

  task automatic build_table();
    int i;
    print_strs[0] = "Hello, MIPS!";
    print_strs[1] = "sp";
    for (i = 0; i < 8; i++) add_entry(OP_LOAD, CFG_TEXT_LO, 4 * i, $urandom(), 0);
    add_entry(OP_LOAD,  CFG_TEXT_LO, 32'h200, $urandom(), 0);
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h000, '0, 8);
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h200, '0, 1);
    add_entry(OP_WRITE, CFG_TEXT_LO, 32'h410, $urandom(), 0);
    add_entry(OP_WRITE, CFG_TEXT_LO, 32'h414, $urandom(), 0);
    add_entry(OP_READ,  CFG_TEXT_LO, 32'h410, '0, 0);
    add_entry(OP_READ,  CFG_TEXT_LO, 32'h414, '0, 0);
    add_entry(OP_WRITE, CFG_TEXT_LO, 32'h420, $urandom(), 0);
    add_entry(OP_RDWR,  CFG_TEXT_LO, 32'h420, $urandom(), 0);
    add_entry(OP_READ,  CFG_TEXT_LO, 32'h420, '0, 0);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_WRITE, CFG_TEXT_LO, 32'h810, $urandom(), 0);  // Aliases 0x410.
    add_entry(OP_READ,  CFG_TEXT_LO, 32'h410, '0, 0);
    add_entry(OP_READ,  CFG_TEXT_LO, 32'h810, '0, 0);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_LOAD,  CFG_TEXT_LO, 32'h400, $urandom(), 0);  // Aliases word 0.
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h000, '0, 1);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_CFG,   CFG_FAULT_CLR, '0, '0, 0);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_CFG,   CFG_TEXT_HI, 32'h0ff, '0, 0);
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h200, '0, 1);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_CFG,   CFG_TEXT_HI, 32'h3ff, '0, 0);
    add_entry(OP_CFG,   CFG_FAULT_CLR, '0, '0, 0);
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h200, '0, 1);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
    add_entry(OP_PRINT, CFG_TEXT_LO, 32'h105, '0, 0);  // Unaligned start.
    add_entry(OP_PRINT, CFG_TEXT_LO, 32'h2c3, '0, 1);  // Crosses a word after one char.
    add_entry(OP_FETCH, CFG_TEXT_LO, 32'h000, '0, 8);
    add_entry(OP_FAULT, CFG_TEXT_LO, '0, '0, 0);
  endtask

  task automatic apply_entry(input entry_t e);
    case (e.op)
      OP_LOAD:  drive_load(e.addr, e.data);
      OP_FETCH: run_fetches(e.addr, int'(e.arg));
      OP_WRITE: stack_access(e.addr, e.data, 1'b1, 1'b0);
      OP_READ:  stack_access(e.addr, '0, 1'b0, 1'b1);
      OP_RDWR:  stack_access(e.addr, e.data, 1'b1, 1'b1);
      OP_CFG:   write_cfg(e.sel, e.addr);
      OP_FAULT: check_fault(fault_status, fault_m, "fault status");
      default:  run_print(e.addr, print_strs[e.arg]);
    endcase
  endtask

  // ************************************************************************
  // Run control.
  // ************************************************************************

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: DUT did not finish");
      stop_run();
    end
  end

  initial begin
    fetch_addr = '0;
    data_valid = 1'b0;
    data_req   = '0;
    load_req   = '0;
    cfg_req    = '0;
    print_req  = '0;
    void'($urandom(32'ha323_a321));
    foreach (text_model[i]) text_model[i] = '0;
    foreach (stack_model[i]) stack_model[i] = '0;
    text_win_m  = '{lo: TEXT_LO_DEFAULT, hi: TEXT_HI_DEFAULT};
    stack_win_m = '{lo: STACK_LO_DEFAULT, hi: STACK_HI_DEFAULT};
    fault_m     = '0;
    build_table();
    cycle_limit = stim_q.size() * 64;

    @(negedge reset);
    check_instr(instr_out, '0, "instr_out after reset");
    check_word(rdata, '0, "rdata after reset");
    check_flag(char_out.valid, 1'b0, "char valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(print_done, 1'b0, "print_done after reset");
    check_fault(fault_status, '0, "fault status after reset");

    foreach (stim_q[i]) apply_entry(stim_q[i]);

    $display("Test OK");
    $finish;
  end

endmodule

// ==== src.f ====
hdl/mem_map_pkg.sv
hdl/mem_bus_pkg.sv
hdl/word_ram.sv
hdl/region_cfg.sv
hdl/string_printer.sv
hdl/mips_memory.sv
hdl/mem_subsystem_top.sv
verif/tb_clock_gen.sv
verif/mem_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mips_mem_subsystem

sources:
  # Packages first, then the design bottom up.
  - hdl/mem_map_pkg.sv
  - hdl/mem_bus_pkg.sv
  - hdl/word_ram.sv
  - hdl/region_cfg.sv
  - hdl/string_printer.sv
  - hdl/mips_memory.sv
  - hdl/mem_subsystem_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/mem_subsystem_tb.sv
